/* cmt_defines.svh */
/*
   Commit stage widths and the exception vector reset value
*/
`ifndef CMT_DEFINES_SVH
`define CMT_DEFINES_SVH

// Data path word
`define CMT_DW 32

// Word PC, byte offset dropped
`define CMT_PC_W 30

// Physical register file address
`define CMT_PRF_AW 6

// Commit width and its log2
`define CMT_P_CW 2
`define CMT_CW 4

// EVECT after reset, in words
`define CMT_EVECT_RST 30'h0000_0040

`endif

/* cmt_types_pkg.sv */
/*
   Vector types for the widths used across the commit stage
*/
`include "cmt_defines.svh"

package cmt_types_pkg;

   // One data word
   typedef logic [`CMT_DW-1:0] data_t;

   // Word-aligned PC
   typedef logic [`CMT_PC_W-1:0] pc_t;

   // Physical register address
   typedef logic [`CMT_PRF_AW-1:0] prf_addr_t;

   // One bit per commit slot
   typedef logic [`CMT_CW-1:0] slot_mask_t;

   // Number of slots retired in one cycle
   typedef logic [`CMT_P_CW:0] pop_size_t;

   // Predictor payload: taken bit on top of the predicted target
   typedef logic [`CMT_PC_W:0] bpu_upd_t;

endpackage

/* cmt_ops_pkg.sv */
/*
   Operation encodings seen by the commit stage
*/
package cmt_ops_pkg;

   // Load/store unit
   typedef enum logic [1:0] {
      LSU_NONE  = 2'd0,
      LSU_LOAD  = 2'd1,
      LSU_STORE = 2'd2
   } lsu_op_e;

   // Exception unit
   typedef enum logic [1:0] {
      EPU_NONE = 2'd0,
      EPU_ERET = 2'd1,
      EPU_MFSR = 2'd2,
      EPU_MTSR = 2'd3
   } epu_op_e;

   // Branch kinds reported to the predictor
   typedef enum logic [1:0] {
      BR_NONE = 2'd0,
      BR_BCC  = 2'd1,
      BR_BREL = 2'd2,
      BR_BREG = 2'd3
   } br_kind_e;

   // System register index, low bit of the address operand
   typedef enum logic [0:0] {
      SR_EPC   = 1'b0,
      SR_EVECT = 1'b1
   } sr_idx_e;

endpackage

/* cmt_retire.sv */
/*
   Commit mask, retire count, slot-0 request FSM and unit write-back
*/
`timescale 1ns/1ps
`include "cmt_defines.svh"

module cmt_retire
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  slot_mask_t cmt_valid,
   input  slot_mask_t cmt_fls,
   input  slot_mask_t cmt_exc,
   input  lsu_op_e    cmt_lsu_opc [0:`CMT_CW-1],
   input  epu_op_e    cmt_epu_opc [0:`CMT_CW-1],
   input  br_kind_e   cmt_br_kind [0:`CMT_CW-1],
   input  prf_addr_t  cmt_prd,
   input  logic       cmt_prd_we,
   input  logic       flush,
   input  logic       se_fls,
   input  logic       lsu_wb_valid,
   input  logic       epu_wb_valid,
   input  logic       epu_wb_dout_sel,
   input  data_t      lsu_wb_dout,
   input  data_t      epu_wb_dout,
   output slot_mask_t cmt_fire,
   output pop_size_t  cmt_pop_size,
   output logic       lsu_req_valid,
   output logic       epu_req_valid,
   output logic       prf_we,
   output prf_addr_t  prf_waddr,
   output data_t      prf_wdata
);
   typedef enum logic {S_IDLE, S_PENDING} req_state_e;

   req_state_e state;
   req_state_e state_nxt;
   slot_mask_t lsu_req;
   slot_mask_t epu_req;
   slot_mask_t single_fu;
   slot_mask_t cmt_mask;
   logic       pipe_req;
   logic       pipe_finish;
   logic       cmt_ce;

   always_comb
      begin
         for (int i = 0; i < `CMT_CW; i++)
            begin
               lsu_req[i] = ~se_fls & (cmt_lsu_opc[i] != LSU_NONE);
               epu_req[i] = ~se_fls & ((cmt_epu_opc[i] != EPU_NONE) | cmt_exc[i]);
               single_fu[i] = lsu_req[i] | epu_req[i] | cmt_fls[i] | (cmt_br_kind[i] != BR_NONE);
            end
      end

   assign pipe_req = cmt_valid[0] & (lsu_req[0] | epu_req[0]);
   assign pipe_finish = lsu_wb_valid | epu_wb_valid;
   assign cmt_ce = ~pipe_req | pipe_finish; // Slot 0 held until its unit is done

   // Prefix stops at the first later slot that needs slot 0
   always_comb
      begin
         cmt_mask[0] = cmt_ce & ~flush;
         for (int i = 1; i < `CMT_CW; i++)
            cmt_mask[i] = cmt_mask[i-1] & ~single_fu[i];
      end

   assign cmt_fire = cmt_valid & cmt_mask;

   always_comb
      begin
         cmt_pop_size = '0;
         for (int i = 0; i < `CMT_CW; i++)
            cmt_pop_size = cmt_pop_size + pop_size_t'(cmt_fire[i]);
      end

   always_comb
      begin
         state_nxt = state;
         case (state)
            S_IDLE:
               if (pipe_req)
                  state_nxt = S_PENDING;
            S_PENDING:
               if (pipe_finish)
                  state_nxt = S_IDLE; // Also on an exception flush
            default:
               state_nxt = S_IDLE;
         endcase
      end

   always_ff @(posedge clk)
      begin
         if (rst)
            state <= S_IDLE;
         else
            state <= state_nxt;
      end

   assign lsu_req_valid = (state == S_IDLE) & cmt_valid[0] & lsu_req[0];
   assign epu_req_valid = (state == S_IDLE) & cmt_valid[0] & epu_req[0];

   assign prf_we = pipe_finish & ~flush & cmt_prd_we;
   assign prf_waddr = cmt_prd;
   assign prf_wdata = epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout;

endmodule

/* cmt_redirect.sv */
/*
   Self-flush register, flush priority and branch predictor update
*/
`timescale 1ns/1ps
`include "cmt_defines.svh"

module cmt_redirect
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     fire0,
   input  logic     fls0,
   input  br_kind_e br_kind0,
   input  pc_t      cmt_pc,
   input  data_t    cmt_opera,
   input  bpu_upd_t cmt_bpu_upd,
   input  logic     refetch,
   input  logic     exc_flush,
   input  pc_t      exc_flush_tgt,
   output logic     flush,
   output pc_t      flush_tgt,
   output logic     se_fls,
   output pc_t      npc,
   output logic     bpu_wb,
   output br_kind_e bpu_wb_kind,
   output logic     bpu_wb_taken,
   output pc_t      bpu_wb_pc,
   output pc_t      bpu_wb_npc_act,
   output bpu_upd_t bpu_wb_upd
);
   pc_t se_tgt;
   pc_t act_tgt;

   assign npc = cmt_pc + 1'b1;
   assign act_tgt = cmt_opera[`CMT_PC_W-1:0]; // Resolved target of a mispredict

   // One-cycle pulse after a slot-0 fire
   always_ff @(posedge clk)
      begin
         if (rst)
            se_fls <= 1'b0;
         else
            se_fls <= fire0 & (fls0 | refetch);
      end

   always_ff @(posedge clk)
      begin
         if (fire0)
            se_tgt <= fls0 ? act_tgt : npc; // Refetch restarts at the next PC
      end

   assign flush = se_fls | exc_flush;
   assign flush_tgt = se_fls ? se_tgt : exc_flush_tgt; // Self flush wins

   assign bpu_wb = fire0 & (br_kind0 != BR_NONE);
   assign bpu_wb_kind = br_kind0;
   assign bpu_wb_taken = cmt_bpu_upd[`CMT_PC_W] ^ fls0; // Mispredict flips the guess
   assign bpu_wb_pc = cmt_pc;
   assign bpu_wb_npc_act = fls0 ? act_tgt : cmt_bpu_upd[`CMT_PC_W-1:0];
   assign bpu_wb_upd = cmt_bpu_upd;

endmodule

/* cmt_mem_port.sv */
/*
   Simplified load/store unit, one access held on the strobes until ack
*/
`timescale 1ns/1ps

module cmt_mem_port
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    lsu_req_valid,
   input  lsu_op_e lsu_op,
   input  data_t   cmt_opera,
   input  data_t   cmt_operb,
   input  logic    mem_ack,
   input  data_t   mem_rdata,
   output logic    mem_req,
   output logic    mem_we,
   output data_t   mem_addr,
   output data_t   mem_wdata,
   output logic    lsu_wb_valid,
   output data_t   lsu_wb_dout
);

   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               mem_req <= 1'b0;
               mem_we <= 1'b0;
            end
         else if (lsu_req_valid)
            begin
               mem_req <= 1'b1;
               mem_we <= (lsu_op == LSU_STORE);
            end
         else if (mem_ack)
            mem_req <= 1'b0; // Drops after the ack cycle
      end

   always_ff @(posedge clk)
      begin
         if (lsu_req_valid)
            begin
               mem_addr <= cmt_opera;
               mem_wdata <= cmt_operb;
            end
      end

   assign lsu_wb_valid = mem_req & mem_ack;
   assign lsu_wb_dout = mem_rdata;

endmodule

/* cmt_epu.sv */
/*
   Simplified exception unit holding EPC and EVECT
   Finishes one cycle after its request
*/
`timescale 1ns/1ps
`include "cmt_defines.svh"

module cmt_epu
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    epu_req_valid,
   input  epu_op_e epu_op,
   input  logic    cmt_exc0,
   input  pc_t     cmt_pc,
   input  pc_t     npc,
   input  data_t   cmt_opera,
   input  data_t   cmt_operb,
   output logic    epu_wb_valid,
   output data_t   epu_wb_dout,
   output logic    epu_wb_dout_sel,
   output logic    exc_flush,
   output pc_t     exc_flush_tgt,
   output logic    refetch
);
   pc_t     epc;
   pc_t     evect;
   pc_t     sr_rdata;
   sr_idx_e sr_sel;
   logic    is_eret;
   logic    is_mtsr;

   // Slot 0 stays put while pending, so its fields are still valid here
   always_ff @(posedge clk)
      begin
         if (rst)
            epu_wb_valid <= 1'b0;
         else
            epu_wb_valid <= epu_req_valid;
      end

   assign sr_sel = sr_idx_e'(cmt_opera[0]);
   assign is_eret = ~cmt_exc0 & (epu_op == EPU_ERET); // Exception beats the op field
   assign is_mtsr = ~cmt_exc0 & (epu_op == EPU_MTSR);

   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               epc <= '0;
               evect <= `CMT_EVECT_RST;
            end
         else if (epu_wb_valid)
            begin
               if (cmt_exc0)
                  epc <= cmt_pc; // Faulting instruction
               else if (is_mtsr && sr_sel == SR_EPC)
                  epc <= cmt_operb[`CMT_PC_W-1:0];
               else if (is_mtsr && sr_sel == SR_EVECT)
                  evect <= cmt_operb[`CMT_PC_W-1:0];
            end
      end

   assign sr_rdata = (sr_sel == SR_EVECT) ? evect : epc;
   assign epu_wb_dout = data_t'(sr_rdata);
   assign epu_wb_dout_sel = epu_wb_valid;

   assign exc_flush = epu_wb_valid & (cmt_exc0 | is_eret);
   assign refetch = epu_wb_valid & is_mtsr;

   always_comb
      begin
         if (cmt_exc0)
            exc_flush_tgt = evect;
         else if (is_eret)
            exc_flush_tgt = epc;
         else
            exc_flush_tgt = npc; // Resume point of a refetch
      end

endmodule

/* cmt_top.sv */
/*
   Commit stage top level, retires an in-order prefix of four ROB slots
*/
`timescale 1ns/1ps
`include "cmt_defines.svh"

module cmt
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  slot_mask_t cmt_valid,
   input  slot_mask_t cmt_fls,
   input  slot_mask_t cmt_exc,
   input  lsu_op_e    cmt_lsu_opc [0:`CMT_CW-1],
   input  epu_op_e    cmt_epu_opc [0:`CMT_CW-1],
   input  br_kind_e   cmt_br_kind [0:`CMT_CW-1],
   input  pc_t        cmt_pc,
   input  data_t      cmt_opera,
   input  data_t      cmt_operb,
   input  bpu_upd_t   cmt_bpu_upd,
   input  prf_addr_t  cmt_prd,
   input  logic       cmt_prd_we,
   output slot_mask_t cmt_fire,
   output pop_size_t  cmt_pop_size,
   output logic       flush,
   output pc_t        flush_tgt,
   output logic       bpu_wb,
   output br_kind_e   bpu_wb_kind,
   output logic       bpu_wb_taken,
   output pc_t        bpu_wb_pc,
   output pc_t        bpu_wb_npc_act,
   output bpu_upd_t   bpu_wb_upd,
   output logic       prf_we,
   output prf_addr_t  prf_waddr,
   output data_t      prf_wdata,
   output logic       mem_req,
   output logic       mem_we,
   output data_t      mem_addr,
   output data_t      mem_wdata,
   input  logic       mem_ack,
   input  data_t      mem_rdata
);
   logic  lsu_req_valid;
   logic  epu_req_valid;
   logic  lsu_wb_valid;
   data_t lsu_wb_dout;
   logic  epu_wb_valid;
   data_t epu_wb_dout;
   logic  epu_wb_dout_sel;
   logic  exc_flush;
   pc_t   exc_flush_tgt;
   logic  refetch;
   logic  se_fls;
   pc_t   npc;

   cmt_retire u_retire (.clk(clk), .rst(rst), .cmt_valid(cmt_valid), .cmt_fls(cmt_fls),
      .cmt_exc(cmt_exc), .cmt_lsu_opc(cmt_lsu_opc), .cmt_epu_opc(cmt_epu_opc),
      .cmt_br_kind(cmt_br_kind), .cmt_prd(cmt_prd), .cmt_prd_we(cmt_prd_we), .flush(flush),
      .se_fls(se_fls), .lsu_wb_valid(lsu_wb_valid), .epu_wb_valid(epu_wb_valid),
      .epu_wb_dout_sel(epu_wb_dout_sel), .lsu_wb_dout(lsu_wb_dout), .epu_wb_dout(epu_wb_dout),
      .cmt_fire(cmt_fire), .cmt_pop_size(cmt_pop_size), .lsu_req_valid(lsu_req_valid),
      .epu_req_valid(epu_req_valid), .prf_we(prf_we), .prf_waddr(prf_waddr),
      .prf_wdata(prf_wdata));

   cmt_redirect u_redirect (.clk(clk), .rst(rst), .fire0(cmt_fire[0]), .fls0(cmt_fls[0]),
      .br_kind0(cmt_br_kind[0]), .cmt_pc(cmt_pc), .cmt_opera(cmt_opera),
      .cmt_bpu_upd(cmt_bpu_upd), .refetch(refetch), .exc_flush(exc_flush),
      .exc_flush_tgt(exc_flush_tgt), .flush(flush), .flush_tgt(flush_tgt), .se_fls(se_fls),
      .npc(npc), .bpu_wb(bpu_wb), .bpu_wb_kind(bpu_wb_kind), .bpu_wb_taken(bpu_wb_taken),
      .bpu_wb_pc(bpu_wb_pc), .bpu_wb_npc_act(bpu_wb_npc_act), .bpu_wb_upd(bpu_wb_upd));

   cmt_mem_port u_mem_port (.clk(clk), .rst(rst), .lsu_req_valid(lsu_req_valid),
      .lsu_op(cmt_lsu_opc[0]), .cmt_opera(cmt_opera), .cmt_operb(cmt_operb),
      .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_we(mem_we),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .lsu_wb_valid(lsu_wb_valid),
      .lsu_wb_dout(lsu_wb_dout));

   cmt_epu u_epu (.clk(clk), .rst(rst), .epu_req_valid(epu_req_valid),
      .epu_op(cmt_epu_opc[0]), .cmt_exc0(cmt_exc[0]), .cmt_pc(cmt_pc), .npc(npc),
      .cmt_opera(cmt_opera), .cmt_operb(cmt_operb), .epu_wb_valid(epu_wb_valid),
      .epu_wb_dout(epu_wb_dout), .epu_wb_dout_sel(epu_wb_dout_sel), .exc_flush(exc_flush),
      .exc_flush_tgt(exc_flush_tgt), .refetch(refetch));

endmodule

/* cmt_asserts.sv */
/*
   Concurrent checks on the commit stage outputs, bound to the top level
*/
`timescale 1ns/1ps

module cmt_asserts
   import cmt_types_pkg::*;
(
   input logic       clk,
   input logic       rst,
   input logic       flush,
   input slot_mask_t cmt_fire,
   input logic       prf_we,
   input logic       mem_req,
   input logic       mem_ack,
   input logic       mem_we,
   input data_t      mem_addr,
   input data_t      mem_wdata
);

   no_fire_on_flush: assert property (@(posedge clk) disable iff (rst)
      flush |-> !cmt_fire[0])
      else $error("slot 0 retired in a flush cycle");

   // Request level and its fields hold until the ack cycle
   mem_req_held: assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr)
         && $stable(mem_wdata))
      else $error("memory request dropped or changed before its ack");

   no_write_on_flush: assert property (@(posedge clk) disable iff (rst)
      flush |-> !prf_we)
      else $error("register file written in a flush cycle");

endmodule

bind cmt cmt_asserts u_asserts (.clk(clk), .rst(rst), .flush(flush), .cmt_fire(cmt_fire),
   .prf_we(prf_we), .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we),
   .mem_addr(mem_addr), .mem_wdata(mem_wdata));

/* tb_cmt.sv */
/*
   Testbench for the commit stage with random slot contents checked against a model
*/
`timescale 1ns/1ps
`include "cmt_defines.svh"

module tb_cmt;
   import cmt_types_pkg::*;
   import cmt_ops_pkg::*;

   localparam int N_COMMIT = 150;
   localparam int N_BRANCH = 150;
   localparam int N_MEM = 40;
   localparam int N_EPU = 30;
   localparam int WORST_LAT = 6; // Request, strobe, three waits, ack
   localparam int MAX_CYCLES = 2 * (N_COMMIT + N_BRANCH + N_MEM + N_EPU) * WORST_LAT;

   logic       clk;
   logic       rst;
   slot_mask_t cmt_valid, cmt_fls, cmt_exc;
   lsu_op_e    cmt_lsu_opc [0:`CMT_CW-1];
   epu_op_e    cmt_epu_opc [0:`CMT_CW-1];
   br_kind_e   cmt_br_kind [0:`CMT_CW-1];
   pc_t        cmt_pc;
   data_t      cmt_opera, cmt_operb;
   bpu_upd_t   cmt_bpu_upd;
   prf_addr_t  cmt_prd;
   logic       cmt_prd_we;
   slot_mask_t cmt_fire;
   pop_size_t  cmt_pop_size;
   logic       flush;
   pc_t        flush_tgt;
   logic       bpu_wb, bpu_wb_taken;
   br_kind_e   bpu_wb_kind;
   pc_t        bpu_wb_pc, bpu_wb_npc_act;
   bpu_upd_t   bpu_wb_upd;
   logic       prf_we;
   prf_addr_t  prf_waddr;
   data_t      prf_wdata;
   logic       mem_req, mem_we, mem_ack;
   data_t      mem_addr, mem_wdata, mem_rdata;

   integer seed;
   int     errors;
   int     checks;
   int     cycle_cnt = 0;
   int     ack_delay;
   int     wait_cnt;
   logic   busy;
   pc_t    epc_m; // Model of the exception registers
   pc_t    evect_m;

   cmt UUT (.*);

   initial
      begin
         clk = 1'b0;
         forever #4 clk = ~clk;
      end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   initial
      begin
         wait (cycle_cnt >= MAX_CYCLES);
         $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end

   function automatic data_t mem_value(input data_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   // Memory responder acking ack_delay cycles after mem_req rises
   initial
      begin
         mem_ack = 1'b0;
         mem_rdata = '0;
         busy = 1'b0;
         wait_cnt = 0;
         forever
            begin
               @(posedge clk);
               #1;
               if (!mem_req || mem_ack)
                  begin
                     mem_ack = 1'b0;
                     busy = 1'b0;
                  end
               else
                  begin
                     if (!busy)
                        begin
                           busy = 1'b1;
                           wait_cnt = ack_delay;
                        end
                     if (wait_cnt == 0)
                        begin
                           mem_ack = 1'b1;
                           mem_rdata = mem_value(mem_addr);
                        end
                     else
                        wait_cnt = wait_cnt - 1;
                  end
            end
      end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
         begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
         end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic clear_slots();
      cmt_valid = '0;
      cmt_fls = '0;
      cmt_exc = '0;
      for (int i = 0; i < `CMT_CW; i++)
         begin
            cmt_lsu_opc[i] = LSU_NONE;
            cmt_epu_opc[i] = EPU_NONE;
            cmt_br_kind[i] = BR_NONE;
         end
      cmt_pc = '0;
      cmt_opera = '0;
      cmt_operb = '0;
      cmt_bpu_upd = '0;
      cmt_prd = '0;
      cmt_prd_we = 1'b0;
   endtask

   task automatic report(input string name, input int n, input int err_start);
      $display("%s: %0d transactions, %0d errors", name, n, errors - err_start);
   endtask

   task automatic commit_prefix();
      logic [31:0] r;
      slot_mask_t  exp_fire;
      logic        stop;
      int          pop;
      for (int n = 0; n < N_COMMIT; n++)
         begin
            clear_slots();
            r = $random(seed);
            cmt_valid = r[3:0];
            for (int i = 1; i < `CMT_CW; i++)
               begin
                  r = $random(seed);
                  cmt_lsu_opc[i] = (r[2:0] == 3'd0) ? LSU_STORE : LSU_NONE;
                  cmt_epu_opc[i] = (r[5:3] == 3'd0) ? EPU_ERET : EPU_NONE;
                  cmt_exc[i] = (r[8:6] == 3'd0);
                  cmt_fls[i] = (r[11:9] == 3'd0);
                  cmt_br_kind[i] = (r[14:12] == 3'd0) ? BR_BREL : BR_NONE;
               end
            exp_fire = '0;
            exp_fire[0] = cmt_valid[0];
            stop = 1'b0;
            for (int i = 1; i < `CMT_CW; i++)
               begin
                  stop = stop | (cmt_lsu_opc[i] != LSU_NONE) | (cmt_epu_opc[i] != EPU_NONE)
                     | cmt_exc[i] | cmt_fls[i] | (cmt_br_kind[i] != BR_NONE);
                  exp_fire[i] = cmt_valid[i] & ~stop;
               end
            pop = 0;
            for (int i = 0; i < `CMT_CW; i++)
               pop = pop + int'(exp_fire[i]);
            @(negedge clk);
            check("cmt_fire", 32'(cmt_fire), 32'(exp_fire));
            check("cmt_pop_size", 32'(cmt_pop_size), 32'(pop));
            check("bpu_wb", 32'(bpu_wb), 32'd0);
            step();
         end
      clear_slots();
      step();
   endtask

   task automatic branch_and_flush();
      logic [31:0] r;
      logic [31:0] r2;
      logic        exp_flush;
      logic        exp_fire0;
      pc_t         prev_tgt;
      exp_flush = 1'b0;
      prev_tgt = '0;
      for (int n = 0; n < N_BRANCH; n++)
         begin
            r = $random(seed);
            r2 = $random(seed);
            clear_slots();
            cmt_valid = 4'b0001;
            cmt_br_kind[0] = br_kind_e'(r[1:0]);
            cmt_fls[0] = (r[3:2] == 2'd0);
            cmt_bpu_upd = {r[4], r2[29:0]};
            cmt_pc = r[31:2];
            cmt_opera = $random(seed);
            exp_fire0 = ~exp_flush; // Flush cycle retires nothing
            @(negedge clk);
            check("flush", 32'(flush), 32'(exp_flush));
            if (exp_flush)
               check("flush_tgt", 32'(flush_tgt), 32'(prev_tgt));
            check("cmt_fire", 32'(cmt_fire), 32'(exp_fire0));
            check("bpu_wb", 32'(bpu_wb), 32'(exp_fire0 & (cmt_br_kind[0] != BR_NONE)));
            if (exp_fire0 && cmt_br_kind[0] != BR_NONE)
               begin
                  check("bpu_wb_kind", 32'(bpu_wb_kind), 32'(cmt_br_kind[0]));
                  check("bpu_wb_taken", 32'(bpu_wb_taken),
                     32'(cmt_bpu_upd[`CMT_PC_W] ^ cmt_fls[0]));
                  check("bpu_wb_npc_act", 32'(bpu_wb_npc_act), 32'(cmt_fls[0] ?
                     cmt_opera[`CMT_PC_W-1:0] : cmt_bpu_upd[`CMT_PC_W-1:0]));
                  check("bpu_wb_pc", 32'(bpu_wb_pc), 32'(cmt_pc));
                  check("bpu_wb_upd", 32'(bpu_wb_upd), 32'(cmt_bpu_upd));
               end
            exp_flush = exp_fire0 & cmt_fls[0];
            prev_tgt = cmt_opera[`CMT_PC_W-1:0];
            step();
         end
      clear_slots();
      step();
   endtask

   task automatic load_store();
      logic [31:0] r;
      data_t       addr;
      data_t       wdata;
      logic        is_store;
      logic        done;
      for (int n = 0; n < N_MEM; n++)
         begin
            r = $random(seed);
            addr = $random(seed);
            wdata = $random(seed);
            is_store = r[0];
            clear_slots();
            cmt_valid = 4'b0001;
            cmt_lsu_opc[0] = is_store ? LSU_STORE : LSU_LOAD;
            cmt_opera = addr;
            cmt_operb = wdata;
            cmt_prd = r[7:2];
            cmt_prd_we = ~is_store & r[1];
            ack_delay = int'(r[9:8]);
            done = 1'b0;
            @(negedge clk);
            check("cmt_fire", 32'(cmt_fire), 32'd0);
            while (!done)
               begin
                  step();
                  @(negedge clk);
                  check("mem_req", 32'(mem_req), 32'd1);
                  check("mem_we", 32'(mem_we), 32'(is_store));
                  check("mem_addr", mem_addr, addr);
                  if (is_store)
                     check("mem_wdata", mem_wdata, wdata);
                  if (mem_ack)
                     begin
                        check("cmt_fire", 32'(cmt_fire), 32'd1);
                        check("cmt_pop_size", 32'(cmt_pop_size), 32'd1);
                        check("prf_we", 32'(prf_we), 32'(cmt_prd_we));
                        if (cmt_prd_we)
                           begin
                              check("prf_waddr", 32'(prf_waddr), 32'(cmt_prd));
                              check("prf_wdata", prf_wdata, mem_value(addr));
                           end
                        done = 1'b1;
                     end
                  else
                     check("cmt_fire", 32'(cmt_fire), 32'd0); // Held while pending
               end
            step();
         end
      clear_slots();
      step();
   endtask

   task automatic exception_unit();
      logic [31:0] r;
      logic [31:0] r2;
      data_t       opb;
      logic        exc;
      logic        sr;
      epu_op_e     op;
      pc_t         pc;
      pc_t         next_pc;
      logic [4:0]  fixed_exc;
      logic [4:0]  fixed_sr;
      epu_op_e     fixed_op [5];
      // Exception, read EPC, write EVECT, exception, return
      fixed_exc = 5'b01001;
      fixed_sr = 5'b00100;
      fixed_op = '{EPU_NONE, EPU_MFSR, EPU_MTSR, EPU_NONE, EPU_ERET};
      for (int n = 0; n < N_EPU; n++)
         begin
            r = $random(seed);
            r2 = $random(seed);
            opb = $random(seed);
            exc = (n < 5) ? fixed_exc[n] : (r[1:0] == 2'd0);
            sr = (n < 5) ? fixed_sr[n] : r[2];
            op = (n < 5) ? fixed_op[n] : epu_op_e'(r[4:3]);
            if (!exc && op == EPU_NONE)
               op = EPU_MFSR;
            pc = r2[29:0];
            next_pc = pc + 30'd1;
            clear_slots();
            cmt_valid = 4'b0001;
            cmt_pc = pc;
            cmt_exc[0] = exc;
            cmt_epu_opc[0] = op; // Ignored under an exception
            cmt_opera = {r2[31:1], sr};
            cmt_operb = opb;
            cmt_prd = r[10:5];
            cmt_prd_we = ~exc & (op == EPU_MFSR);
            @(negedge clk);
            check("cmt_fire", 32'(cmt_fire), 32'd0);
            step();
            @(negedge clk);
            if (exc || op == EPU_ERET)
               begin
                  check("flush", 32'(flush), 32'd1);
                  check("flush_tgt", 32'(flush_tgt), 32'(exc ? evect_m : epc_m));
                  check("cmt_fire", 32'(cmt_fire), 32'd0);
                  check("prf_we", 32'(prf_we), 32'd0);
               end
            else
               begin
                  check("flush", 32'(flush), 32'd0);
                  check("cmt_fire", 32'(cmt_fire), 32'd1);
                  check("prf_we", 32'(prf_we), 32'(op == EPU_MFSR));
                  if (op == EPU_MFSR)
                     begin
                        check("prf_waddr", 32'(prf_waddr), 32'(cmt_prd));
                        check("prf_wdata", prf_wdata, 32'(sr ? evect_m : epc_m));
                     end
               end
            if (exc)
               epc_m = pc;
            else if (op == EPU_MTSR && sr)
               evect_m = opb[`CMT_PC_W-1:0];
            else if (op == EPU_MTSR)
               epc_m = opb[`CMT_PC_W-1:0];
            step();
            clear_slots();
            @(negedge clk);
            check("flush", 32'(flush), 32'(!exc && op == EPU_MTSR)); // Refetch
            if (!exc && op == EPU_MTSR)
               check("flush_tgt", 32'(flush_tgt), 32'(next_pc));
            step();
         end
   endtask

   initial
      begin
         int err_start;
         seed = 32'hadb6_e91f;
         errors = 0;
         checks = 0;
         ack_delay = 0;
         epc_m = '0;
         evect_m = `CMT_EVECT_RST;
         rst = 1'b1;
         clear_slots();
         repeat (3) @(posedge clk);
         #1;
         rst = 1'b0;
         @(negedge clk);
         check("flush", 32'(flush), 32'd0);
         check("mem_req", 32'(mem_req), 32'd0);
         check("prf_we", 32'(prf_we), 32'd0);
         check("bpu_wb", 32'(bpu_wb), 32'd0);
         check("cmt_fire", 32'(cmt_fire), 32'd0);
         report("reset state", 1, 0);
         step();
         err_start = errors;
         commit_prefix();
         report("plain commit", N_COMMIT, err_start);
         err_start = errors;
         branch_and_flush();
         report("branch update and mispredict flush", N_BRANCH, err_start);
         err_start = errors;
         load_store();
         report("load/store", N_MEM, err_start);
         err_start = errors;
         exception_unit();
         report("exception unit", N_EPU, err_start);
         $display("Summary: %0d checks, %0d errors", checks, errors);
         if (errors == 0)
            $display("TEST OK");
         else
            $display("TEST FAILED");
         $finish;
      end

endmodule

/* cmt.f */
+incdir+.
cmt_types_pkg.sv
cmt_ops_pkg.sv
cmt_retire.sv
cmt_redirect.sv
cmt_mem_port.sv
cmt_epu.sv
cmt_top.sv
cmt_asserts.sv
tb_cmt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the commit stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cmt -f cmt.f -o sim_cmt
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_cmt)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
exit 1
